// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // data and address words
  typedef logic [31:0] word_t;

  typedef logic [3:0] strb_t;  // one bit per byte lane

  typedef logic [2:0] funct3_t;

  typedef logic [1:0] lane_t;  // byte offset inside a word

  // func3 codes shared by loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  localparam int IO_SEL_BIT = 31;  // high half of the map is the uart

endpackage

`default_nettype wire

// ==== uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  typedef logic [7:0] byte_t;  // serial payload

  typedef logic [2:0] bit_idx_t;  // data bit counter

  // 8N1 frame sequence
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_t;

endpackage

`default_nettype wire

// ==== baud_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module baud_timer #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic clk,
  input  logic arst_n,
  input  logic baud_en,
  output logic baud_tick
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  logic [CNT_W-1:0] cnt;

  assign baud_tick = baud_en && (cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (!baud_en || baud_tick) begin
      cnt <= '0;  // idle or wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== uart_tx_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fsm (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            tx_load,
  input  uart_pkg::byte_t tx_byte,
  input  logic            baud_tick,
  output logic            baud_en,
  output logic            uart_tx,
  output logic            uart_busy
);

  import uart_pkg::*;

  tx_state_t state;
  byte_t     shift_q;
  bit_idx_t  bit_cnt;

  assign uart_busy = (state != IDLE);
  assign baud_en   = (state != IDLE);  // timer runs for the whole frame

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      uart_tx <= 1'b1;
      bit_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (tx_load) begin
            state   <= START;
            uart_tx <= 1'b0;  // start bit
          end
        end
        START: begin
          if (baud_tick) begin
            state   <= DATA;
            uart_tx <= shift_q[0];
          end
        end
        DATA: begin
          if (baud_tick) begin
            bit_cnt <= bit_cnt + 3'd1;  // wraps to 0 after bit 7
            if (bit_cnt == 3'd7) begin
              state   <= STOP;
              uart_tx <= 1'b1;
            end else begin
              uart_tx <= shift_q[0];
            end
          end
        end
        default: begin
          if (baud_tick) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (state == IDLE && tx_load) begin
      shift_q <= tx_byte;
    end else if (baud_tick && (state == START || state == DATA)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_ram #(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  clk,
  input  logic [MEM_ADDR_W-1:0] mem_addr,
  input  lsu_pkg::word_t        mem_wdata,
  input  lsu_pkg::strb_t        mem_mask,
  input  logic                  mem_cs_n,
  input  logic                  mem_read_n,
  output lsu_pkg::word_t        ram_rdata
);

  import lsu_pkg::*;

  word_t mem [2**MEM_ADDR_W];

  always_ff @(posedge clk) begin
    if (!mem_cs_n) begin
      if (mem_read_n) begin
        for (int i = 0; i < 4; i++) begin
          if (mem_mask[i]) begin
            mem[mem_addr][8*i +: 8] <= mem_wdata[8*i +: 8];  // masked lane write
          end
        end
      end else begin
        ram_rdata <= mem[mem_addr];  // holds until next read
      end
    end
  end

endmodule

`default_nettype wire

// ==== mem_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_unit #(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    read_en,
  input  logic                    write_en,
  input  lsu_pkg::funct3_t        func3,
  input  lsu_pkg::word_t          address,
  input  lsu_pkg::word_t          wdata,
  input  lsu_pkg::word_t          ram_rdata,
  input  logic                    uart_busy,
  output lsu_pkg::word_t          rdata,
  output logic                    rdata_valid,
  output logic [MEM_ADDR_W-1:0]   mem_addr,
  output lsu_pkg::word_t          mem_wdata,
  output lsu_pkg::strb_t          mem_mask,
  output logic                    mem_cs_n,
  output logic                    mem_read_n,
  output logic                    tx_load,
  output uart_pkg::byte_t         tx_byte
);

  import lsu_pkg::*;
  import uart_pkg::*;

  logic    is_io;
  lane_t   lane;
  funct3_t rd_func3_q;
  lane_t   rd_lane_q;
  logic    rd_ram_q;
  byte_t   ld_byte;
  logic [15:0] ld_half;

  assign is_io    = address[IO_SEL_BIT];
  assign lane     = address[1:0];
  assign mem_addr = address[MEM_ADDR_W+1:2];  // word address
  assign tx_byte  = wdata[8*lane +: 8];

  // request decode
  always_comb begin
    mem_cs_n   = 1'b1;
    mem_read_n = 1'b1;
    mem_mask   = '0;
    mem_wdata  = '0;
    tx_load    = 1'b0;
    if (read_en) begin
      mem_read_n = 1'b0;
      mem_mask   = 4'b1111;
      if (!is_io) begin
        mem_cs_n = 1'b0;
      end
    end else if (write_en) begin
      if (!is_io) begin
        mem_cs_n = 1'b0;
        case (func3)
          F3_B:    mem_mask = strb_t'(4'b0001 << lane);
          F3_H:    mem_mask = address[1] ? 4'b1100 : 4'b0011;
          F3_W:    mem_mask = 4'b1111;
          default: mem_mask = '0;  // nothing written
        endcase
        for (int i = 0; i < 4; i++) begin
          mem_wdata[8*i +: 8] = mem_mask[i] ? wdata[8*i +: 8] : 8'h00;
        end
      end else if (func3 == F3_B && !uart_busy) begin
        tx_load = 1'b1;  // dropped while busy
      end
    end
  end

  // load info for the cycle the ram answers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata_valid <= 1'b0;
      rd_func3_q  <= F3_W;
      rd_lane_q   <= '0;
      rd_ram_q    <= 1'b0;
    end else begin
      rdata_valid <= read_en;
      if (read_en) begin
        rd_func3_q <= func3;
        rd_lane_q  <= lane;
        rd_ram_q   <= !is_io;
      end
    end
  end

  assign ld_byte = ram_rdata[8*rd_lane_q +: 8];
  assign ld_half = rd_lane_q[1] ? ram_rdata[31:16] : ram_rdata[15:0];

  // lane select and extension
  always_comb begin
    rdata = '0;
    if (rd_ram_q) begin
      case (rd_func3_q)
        F3_B:    rdata = {{24{ld_byte[7]}}, ld_byte};
        F3_BU:   rdata = {24'h0, ld_byte};
        F3_H:    rdata = {{16{ld_half[15]}}, ld_half};
        F3_HU:   rdata = {16'h0, ld_half};
        F3_W:    rdata = ram_rdata;
        default: rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top #(
  parameter int MEM_ADDR_W   = 8,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             read_en,
  input  logic             write_en,
  input  lsu_pkg::funct3_t func3,
  input  lsu_pkg::word_t   address,
  input  lsu_pkg::word_t   wdata,
  output lsu_pkg::word_t   rdata,
  output logic             rdata_valid,
  output logic             uart_tx,
  output logic             uart_busy
);

  import lsu_pkg::*;
  import uart_pkg::*;

  logic [MEM_ADDR_W-1:0] mem_addr;
  word_t                 mem_wdata;
  word_t                 ram_rdata;
  strb_t                 mem_mask;
  logic                  mem_cs_n;
  logic                  mem_read_n;
  logic                  tx_load;
  byte_t                 tx_byte;
  logic                  baud_en;
  logic                  baud_tick;

  mem_unit #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_mem_unit (
    .clk         (clk),
    .arst_n      (arst_n),
    .read_en     (read_en),
    .write_en    (write_en),
    .func3       (func3),
    .address     (address),
    .wdata       (wdata),
    .ram_rdata   (ram_rdata),
    .uart_busy   (uart_busy),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_mask    (mem_mask),
    .mem_cs_n    (mem_cs_n),
    .mem_read_n  (mem_read_n),
    .tx_load     (tx_load),
    .tx_byte     (tx_byte)
  );

  data_ram #(
    .MEM_ADDR_W (MEM_ADDR_W)
  ) u_data_ram (
    .clk        (clk),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_mask   (mem_mask),
    .mem_cs_n   (mem_cs_n),
    .mem_read_n (mem_read_n),
    .ram_rdata  (ram_rdata)
  );

  uart_tx_fsm u_uart_tx_fsm (
    .clk       (clk),
    .arst_n    (arst_n),
    .tx_load   (tx_load),
    .tx_byte   (tx_byte),
    .baud_tick (baud_tick),
    .baud_en   (baud_en),
    .uart_tx   (uart_tx),
    .uart_busy (uart_busy)
  );

  baud_timer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_baud_timer (
    .clk       (clk),
    .arst_n    (arst_n),
    .baud_en   (baud_en),
    .baud_tick (baud_tick)
  );

endmodule

`default_nettype wire

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;

  import lsu_pkg::*;
  import uart_pkg::*;

  localparam int MEM_ADDR_W   = 8;
  localparam int CLKS_PER_BIT = 8;
  localparam int NW           = 16;  // ram words in use
  localparam int LIMIT        = 40 * CLKS_PER_BIT;

  logic    clk = 1'b0;
  logic    arst_n = 1'b0;
  logic    read_en = 1'b0;
  logic    write_en = 1'b0;
  funct3_t func3 = '0;
  word_t   address = '0;
  word_t   wdata = '0;
  word_t   rdata;
  logic    rdata_valid;
  logic    uart_tx;
  logic    uart_busy;

  integer  seed = 32'h3efb889a;
  int      err_cnt = 0;
  int      chk_cnt = 0;
  int      test_cnt = 0;
  word_t   model_mem [int];  // keyed by word address
  logic [MEM_ADDR_W-1:0] idx_list [NW];
  funct3_t f3_list [5] = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};

  always #5 clk = ~clk;

  mem_subsys_top #(
    .MEM_ADDR_W   (MEM_ADDR_W),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut (.*);

  task automatic check_word(input word_t got, input word_t want, input string msg);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, want);
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t want, input string msg);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, want);
    end
  endtask

  task automatic check_bit(input logic got, input logic want, input string msg);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("Fail at %0t ns: %s, got %b expected %b", $time, msg, got, want);
    end
  endtask

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic word_t ram_addr(input int sel, input lane_t ln);
    word_t a = '0;
    a[MEM_ADDR_W+1:2] = idx_list[sel];
    a[1:0] = ln;
    return a;
  endfunction

  // lane select and extension per the load rules
  function automatic word_t model_load(input funct3_t f3, input word_t addr);
    word_t       w = addr[IO_SEL_BIT] ? '0 : model_mem[int'(addr[MEM_ADDR_W+1:2])];
    byte_t       b = w[8*addr[1:0] +: 8];
    logic [15:0] h = addr[1] ? w[31:16] : w[15:0];
    case (f3)
      F3_B:    return {{24{b[7]}}, b};
      F3_BU:   return {24'h0, b};
      F3_H:    return {{16{h[15]}}, h};
      F3_HU:   return {16'h0, h};
      F3_W:    return w;
      default: return '0;
    endcase
  endfunction

  task automatic store(input funct3_t f3, input word_t addr, input word_t data);
    strb_t m;
    case (f3)
      F3_B:    m = strb_t'(1 << addr[1:0]);
      F3_H:    m = addr[1] ? 4'b1100 : 4'b0011;
      F3_W:    m = 4'b1111;
      default: m = 4'b0000;
    endcase
    write_en = 1'b1;
    func3    = f3;
    address  = addr;
    wdata    = data;
    @(negedge clk);
    write_en = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (m[i] && !addr[IO_SEL_BIT]) begin
        model_mem[int'(addr[MEM_ADDR_W+1:2])][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic load_one(input funct3_t f3, input word_t addr, input string msg);
    word_t want = model_load(f3, addr);
    int    cyc = 0;
    read_en = 1'b1;
    func3   = f3;
    address = addr;
    do begin
      @(negedge clk);
      read_en = 1'b0;
      cyc++;
    end while (!rdata_valid && cyc < LIMIT);
    if (!rdata_valid) begin
      err_cnt++;
      $display("timeout: load from %h never raised rdata_valid", addr);
    end else begin
      check_bit(cyc == 1, 1'b1, "rdata_valid one cycle after read_en");
      check_word(rdata, want, msg);
    end
  endtask

  // a new load every cycle
  task automatic load_burst(input int n, input bit sweep);
    funct3_t f3;
    word_t   a;
    word_t   want;
    for (int k = 0; k < n; k++) begin
      f3   = sweep ? f3_list[(k / 4) % 5] : f3_list[pick(5)];
      a    = ram_addr(pick(NW), sweep ? lane_t'(k) : lane_t'(pick(4)));
      want = model_load(f3, a);
      read_en = 1'b1;
      func3   = f3;
      address = a;
      @(negedge clk);
      check_bit(rdata_valid, 1'b1, "rdata_valid in burst");
      check_word(rdata, want, "burst load data");
    end
    read_en = 1'b0;
    @(negedge clk);
    check_bit(rdata_valid, 1'b0, "rdata_valid drops after burst");
    check_word(rdata, want, "rdata held after burst");
  endtask

  // receiver samples each bit at its centre
  task automatic uart_frame(input bit inject);
    word_t d = $random(seed);
    lane_t ln = lane_t'(pick(4));
    byte_t want = d[8*ln +: 8];
    word_t ram_a = ram_addr(0, 2'd0);
    byte_t rx = '0;
    int    t = 0;
    logic  again = 1'b0;
    store(F3_B, {1'b1, 29'h0, ln}, d);
    while (uart_busy && t < LIMIT) begin
      if (t % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
        if (t / CLKS_PER_BIT == 0) check_bit(uart_tx, 1'b0, "start bit");
        else if (t / CLKS_PER_BIT == 9) check_bit(uart_tx, 1'b1, "stop bit");
        else rx[t / CLKS_PER_BIT - 1] = uart_tx;
      end
      if (inject && t == 3 * CLKS_PER_BIT) store(F3_B, 32'h8000_0000, {4{~want}});  // while busy
      else if (inject && t == 5 * CLKS_PER_BIT) store(F3_W, ram_a, $random(seed));
      else @(negedge clk);
      t++;
    end
    if (uart_busy) begin
      err_cnt++;
      $display("timeout: uart_busy stayed high past the frame");
    end
    check_word(word_t'(t), word_t'(10 * CLKS_PER_BIT), "uart_busy length in cycles");
    check_byte(rx, want, "received uart byte");
    if (inject) begin
      for (int i = 0; i < 12 * CLKS_PER_BIT; i++) begin
        again |= uart_busy;
        @(negedge clk);
      end
      check_bit(again, 1'b0, "second frame after a store made while busy");
      load_one(F3_W, ram_a, "ram store during frame");
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  initial begin
    int    e;
    word_t a;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    e = err_cnt;
    check_bit(rdata_valid, 1'b0, "rdata_valid after reset");
    check_bit(uart_busy, 1'b0, "uart_busy after reset");
    check_bit(uart_tx, 1'b1, "uart_tx after reset");
    end_test("reset", e);

    e = err_cnt;
    for (int i = 0; i < NW; i++) begin
      idx_list[i] = MEM_ADDR_W'(pick(2 ** MEM_ADDR_W));
      store(F3_W, ram_addr(i, 2'd0), $random(seed));  // every used word fully known
    end
    for (int i = 0; i < 40; i++) begin
      a = ram_addr(pick(NW), lane_t'(pick(4)));
      store(f3_list[pick(3)], a, $random(seed));
      load_one(F3_W, {a[31:2], 2'b00}, "word after store");
    end
    end_test("store_load", e);

    e = err_cnt;
    load_burst(20, 1'b1);  // all codes at all lanes
    load_burst(40, 1'b0);
    end_test("load_formats", e);

    e = err_cnt;
    repeat (3) uart_frame(1'b0);
    end_test("uart_frame", e);

    e = err_cnt;
    uart_frame(1'b1);
    end_test("uart_busy_drop", e);

    e = err_cnt;
    for (int i = 0; i < 5; i++) begin
      load_one(f3_list[i], 32'h8000_0000 | word_t'(pick(1024)), "load from uart region");
    end
    end_test("uart_load", e);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
lsu_pkg.sv
uart_pkg.sv
baud_timer.sv
uart_tx_fsm.sv
data_ram.sv
mem_unit.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module tb_mem_subsys -f all.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
if grep -q "sim passed" sim.log; then
  exit 0
fi
exit 1
